// File: Makefile
# Verilator flow for the DVB-ASI transmit path

TOP       ?= asi_tx_tb
FILELIST  ?= all.f
VERILATOR ?= verilator
SEED      ?= 1
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
RUN_ARGS  ?= +verilator+seed+$(SEED) +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
design/asi_pkg.sv
design/asi_byte_fifo.sv
design/asi_symbol_select.sv
design/asi_enc_8b10b.sv
design/asi_serializer.sv
design/asi_tx_top.sv
tests/asi_tx_sva.sv
tests/asi_tx_tb.sv

// File: design/asi_byte_fifo.sv
`timescale 1ns/1ns

module asi_byte_fifo (
	input  logic       clk,
	input  logic       rst,
	input  logic       wr,
	input  logic [7:0] wdata,
	input  logic       pop,
	output logic [7:0] head,
	output logic       empty,
	output logic       full,
	output logic       overflow
);
	import asi_pkg::*;

	// byte storage
	logic [7:0] mem [FIFO_DEPTH];

	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	// one bit wider than the pointers so a full buffer is countable
	logic [FIFO_AW:0] count;

	logic do_wr;
	logic do_rd;

	// full is tested before the pop of the same edge
	assign do_wr = wr && !full;
	assign do_rd = pop && !empty;

	assign empty = (count == '0);
	assign full = (count == (FIFO_AW+1)'(FIFO_DEPTH));

	// first word fall through
	assign head = mem[rd_ptr];

	//////////////////////////////
	// storage write
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wdata;
		end
	end

	//////////////////////////////
	// pointers, level, overflow
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			// pointers wrap on their own at FIFO_DEPTH
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// write and pop together leave the level unchanged
			if (do_wr && !do_rd) begin
				count <= count + 1'b1;
			end else if (do_rd && !do_wr) begin
				count <= count - 1'b1;
			end
			// sticky until reset, a dropped byte is lost for good
			if (wr && full) begin
				overflow <= 1'b1;
			end
		end
	end

endmodule

// File: design/asi_enc_8b10b.sv
`timescale 1ns/1ns

module asi_enc_8b10b (
	input  logic              clk,
	input  logic              rst,
	input  asi_pkg::asi_sym_t  sym,
	input  logic              sym_valid,
	output asi_pkg::asi_code_t code
);
	import asi_pkg::*;

	//////////////////////////////
	// lookup tables, RD- column
	//////////////////////////////

	// 5b/6b, abcdei with a in bit 5
	function automatic logic [5:0] enc6_rdn(input logic [4:0] x);
		case (x)
			5'd0: return 6'b100111;
			5'd1: return 6'b011101;
			5'd2: return 6'b101101;
			5'd3: return 6'b110001;
			5'd4: return 6'b110101;
			5'd5: return 6'b101001;
			5'd6: return 6'b011001;
			5'd7: return 6'b111000;
			5'd8: return 6'b111001;
			5'd9: return 6'b100101;
			5'd10: return 6'b010101;
			5'd11: return 6'b110100;
			5'd12: return 6'b001101;
			5'd13: return 6'b101100;
			5'd14: return 6'b011100;
			5'd15: return 6'b010111;
			5'd16: return 6'b011011;
			5'd17: return 6'b100011;
			5'd18: return 6'b010011;
			5'd19: return 6'b110010;
			5'd20: return 6'b001011;
			5'd21: return 6'b101010;
			5'd22: return 6'b011010;
			5'd23: return 6'b111010;
			5'd24: return 6'b110011;
			5'd25: return 6'b100110;
			5'd26: return 6'b010110;
			5'd27: return 6'b110110;
			5'd28: return 6'b001110;
			5'd29: return 6'b101110;
			5'd30: return 6'b011110;
			default: return 6'b101011;
		endcase
	endfunction

	// 3b/4b, fghj with f in bit 3
	function automatic logic [3:0] enc4_rdn(input logic [2:0] y, input logic a7);
		case (y)
			3'd0: return 4'b1011;
			3'd1: return 4'b1001;
			3'd2: return 4'b0101;
			3'd3: return 4'b1100;
			3'd4: return 4'b1101;
			3'd5: return 4'b1010;
			3'd6: return 4'b0110;
			default: return a7 ? 4'b0111 : 4'b1110;
		endcase
	endfunction

	// abcdeifghj string order to a-in-bit-0 order
	function automatic logic [SYM_BITS-1:0] to_line_order(input logic [SYM_BITS-1:0] v);
		logic [SYM_BITS-1:0] r;
		for (int i = 0; i < SYM_BITS; i++) begin
			r[i] = v[SYM_BITS-1-i];
		end
		return r;
	endfunction

	// disparity the held code was encoded at
	logic rd_pos;
	// held code was unbalanced
	logic code_flip;

	logic is_k;
	logic [4:0] x;
	logic [2:0] y;
	logic rd_in;
	logic rd_mid;
	logic [5:0] tbl6;
	logic [5:0] code6;
	logic unbal6;
	logic [3:0] tbl4;
	logic [3:0] code4;
	logic unbal4;
	logic use_a7;
	logic k_rev;
	logic inv4;

	assign is_k = (sym.kind == SYM_COMMA);
	assign x = sym.value[4:0];
	assign y = sym.value[7:5];

	// line disparity after the held code
	assign rd_in = rd_pos ^ code_flip;

	//////////////////////////////
	// 6b sub-block
	//////////////////////////////

	// comma path is always K28
	assign tbl6 = is_k ? 6'b001111 : enc6_rdn(x);
	assign unbal6 = ($countones(tbl6) != 3);
	// D.07 is balanced but still alternates
	assign code6 = (rd_in && (unbal6 || (!is_k && x == 5'd7))) ? ~tbl6 : tbl6;
	assign rd_mid = rd_in ^ unbal6;

	//////////////////////////////
	// 4b sub-block
	//////////////////////////////

	// alternate x.A7 avoids a run of five across the boundary
	assign use_a7 = is_k ||
		(!rd_mid && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
		(rd_mid && (x == 5'd11 || x == 5'd13 || x == 5'd14));
	assign tbl4 = enc4_rdn(y, use_a7);
	assign unbal4 = (y == 3'd0 || y == 3'd4 || y == 3'd7);

	// K28.1/.2/.5/.6 take the opposite polarity of the data rows
	assign k_rev = is_k && (y == 3'd1 || y == 3'd2 || y == 3'd5 || y == 3'd6);
	assign inv4 = k_rev ? !rd_mid : (rd_mid && (unbal4 || y == 3'd3));
	assign code4 = inv4 ? ~tbl4 : tbl4;

	//////////////////////////////
	// output register
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			code.bits <= COMMA_RDN;
			rd_pos <= 1'b0;
			// K28.5 is unbalanced
			code_flip <= 1'b1;
		end else if (sym_valid) begin
			code.bits <= to_line_order({code6, code4});
			rd_pos <= rd_in;
			code_flip <= unbal6 ^ unbal4;
		end
	end

endmodule

// File: design/asi_pkg.sv
package asi_pkg;

	//////////////////////////////
	// line and fifo geometry
	//////////////////////////////

	// one code group, j..a
	localparam int SYM_BITS = 10;

	// slot counter width, counts 0..SYM_BITS-1
	localparam int SLOT_W = 4;

	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW = 4;

	// request slot, two cycles ahead of the load at the wrap
	localparam int REQ_SLOT = 7;

	//////////////////////////////
	// symbol encodings
	//////////////////////////////

	// comma byte, K28.5
	localparam logic [7:0] K28_5 = 8'hBC;

	// K28.5 at RD-, abcdei fghj = 001111 1010, a in bit 0
	localparam logic [SYM_BITS-1:0] COMMA_RDN = 10'b0101111100;

	// what a symbol slot carries
	typedef enum logic {
		SYM_DATA  = 1'b0,
		SYM_COMMA = 1'b1
	} asi_sym_kind_e;

	// selector to encoder, 9 bits
	typedef struct packed {
		asi_sym_kind_e kind;
		logic [7:0]    value;
	} asi_sym_t;

	// encoder to serializer, bit a first on the line
	typedef struct packed {
		logic [SYM_BITS-1:0] bits;
	} asi_code_t;

endpackage

// File: design/asi_serializer.sv
`timescale 1ns/1ns

module asi_serializer (
	input  logic              clk,
	input  logic              rst,
	input  asi_pkg::asi_code_t code,
	output logic              sym_req,
	output logic              asi_out
);
	import asi_pkg::*;

	// bit slot within the current symbol
	logic [SLOT_W-1:0] slot;
	logic last_slot;

	logic [SYM_BITS-1:0] shreg;

	assign last_slot = (slot == SLOT_W'(SYM_BITS - 1));

	// ahead of the load by the selector and encoder stages
	assign sym_req = (slot == SLOT_W'(REQ_SLOT));

	//////////////////////////////
	// slot counter, modulo 10
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			slot <= '0;
		end else if (last_slot) begin
			slot <= '0;
		end else begin
			slot <= slot + 1'b1;
		end
	end

	//////////////////////////////
	// shift register
	//////////////////////////////

	// starts out holding a comma so the line is never silent
	always_ff @(posedge clk) begin
		if (rst) begin
			shreg <= COMMA_RDN;
		end else if (last_slot) begin
			// new group lands as the counter wraps
			shreg <= code.bits;
		end else begin
			shreg <= {1'b0, shreg[SYM_BITS-1:1]};
		end
	end

	// bit a goes out first
	assign asi_out = shreg[0];

endmodule

// File: design/asi_symbol_select.sv
`timescale 1ns/1ns

module asi_symbol_select (
	input  logic             clk,
	input  logic             rst,
	input  logic             sym_req,
	input  logic [7:0]       head,
	input  logic             empty,
	output logic             pop,
	output asi_pkg::asi_sym_t sym,
	output logic             sym_valid
);
	import asi_pkg::*;

	// kind of the slot being requested
	asi_sym_kind_e next_kind;
	logic [7:0] next_value;

	// an empty fifo means an idle slot
	assign next_kind = empty ? SYM_COMMA : SYM_DATA;
	assign next_value = empty ? K28_5 : head;

	// take the head byte in the request cycle itself
	assign pop = sym_req && !empty;

	//////////////////////////////
	// registered symbol
	//////////////////////////////

	// payload, only looked at with sym_valid
	always_ff @(posedge clk) begin
		if (sym_req) begin
			sym.kind <= next_kind;
			sym.value <= next_value;
		end
	end

	// one cycle after the request
	always_ff @(posedge clk) begin
		if (rst) begin
			sym_valid <= 1'b0;
		end else begin
			sym_valid <= sym_req;
		end
	end

	// head is only meaningful with the fifo non-empty,
	// and the comma value is fixed, so the decision
	// lives entirely in the empty flag sampled at sym_req

endmodule

// File: design/asi_tx_top.sv
`timescale 1ns/1ns

module asi_tx_top (
	input  logic       clk,
	input  logic       rst,
	input  logic       valid,
	input  logic [7:0] data,
	output logic       full,
	output logic       overflow,
	output logic       asi_out
);
	import asi_pkg::*;

	// fifo to selector
	logic [7:0] head;
	logic empty;
	logic pop;

	// serializer to selector
	logic sym_req;

	// selector to encoder
	asi_sym_t sym;
	logic sym_valid;

	// encoder to serializer
	asi_code_t code;

	//////////////////////////////
	// byte buffer
	//////////////////////////////

	asi_byte_fifo u_fifo (
		.clk(clk),
		.rst(rst),
		.wr(valid),
		.wdata(data),
		.pop(pop),
		.head(head),
		.empty(empty),
		.full(full),
		.overflow(overflow)
	);

	// data byte or idle comma per slot
	asi_symbol_select u_select (
		.clk(clk),
		.rst(rst),
		.sym_req(sym_req),
		.head(head),
		.empty(empty),
		.pop(pop),
		.sym(sym),
		.sym_valid(sym_valid)
	);

	// 8b10b with running disparity
	asi_enc_8b10b u_enc (
		.clk(clk),
		.rst(rst),
		.sym(sym),
		.sym_valid(sym_valid),
		.code(code)
	);

	// slot timing and line output
	asi_serializer u_ser (
		.clk(clk),
		.rst(rst),
		.code(code),
		.sym_req(sym_req),
		.asi_out(asi_out)
	);

endmodule

// File: tests/asi_tx_sva.sv
`timescale 1ns/1ns

module asi_tx_sva (
	input logic clk,
	input logic rst,
	input logic valid,
	input logic full,
	input logic sym_req,
	input logic pop,
	input logic overflow,
	input logic asi_out
);
	// failures so far, read by the testbench summary
	int fail_count = 0;

	// cycles since the last request
	logic [3:0] gap;
	logic seen_req;

	// bytes held, counted from the write and pop strobes
	logic [4:0] level;

	always_ff @(posedge clk) begin
		if (rst) begin
			gap <= '0;
			seen_req <= 1'b0;
		end else if (sym_req) begin
			gap <= '0;
			seen_req <= 1'b1;
		end else begin
			gap <= gap + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			level <= '0;
		end else begin
			level <= level + 5'(valid && !full) - 5'(pop);
		end
	end

	//////////////////////////////
	// slot timing and flags
	//////////////////////////////

	// exactly one request every ten cycles
	a_req_period: assert property (@(posedge clk) disable iff (rst)
		seen_req |-> (sym_req == (gap == 4'd9)))
		else begin
			$error("sym_req period is not 10 cycles");
			fail_count = fail_count + 1;
		end

	// sticky until reset
	a_ovf_sticky: assert property (@(posedge clk) disable iff (rst)
		$past(overflow) |-> overflow)
		else begin
			$error("overflow fell without reset");
			fail_count = fail_count + 1;
		end

	// a pop needs a byte that was written and not yet taken
	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
		pop |-> (level != 5'd0))
		else begin
			$error("pop issued on an empty fifo");
			fail_count = fail_count + 1;
		end

	// line always driven once out of reset
	a_out_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(asi_out))
		else begin
			$error("asi_out is unknown");
			fail_count = fail_count + 1;
		end

endmodule

bind asi_tx_top asi_tx_sva u_sva (
	.clk(clk),
	.rst(rst),
	.valid(valid),
	.full(full),
	.sym_req(sym_req),
	.pop(pop),
	.overflow(overflow),
	.asi_out(asi_out)
);

// File: tests/asi_tx_tb.sv
`timescale 1ns/1ns

module asi_tx_tb;

	import asi_pkg::*;

	logic clk;
	logic rst;
	logic valid;
	logic [7:0] data;
	logic full;
	logic overflow;
	logic asi_out;

	integer seed;

	// bytes the fifo took, oldest first
	logic [7:0] exp_q[$];

	// fifo model, one pop per request slot while bytes are held
	int level = 0;
	int cyc = 0;
	logic full_exp;
	logic pop_exp;
	logic take;

	// receive side
	logic [9:0] win = '0;
	logic aligned = 1'b0;
	logic line_rd = 1'b0;
	// disparity from bit counts alone
	logic dsp_rd = 1'b0;
	logic last_bit = 1'b0;
	int run_len = 0;
	int nbits = 0;
	int comma_cnt = 0;
	int acc_cnt = 0;
	logic [10:0] comma_rdn;

	int sym_errs = 0;
	int line_errs = 0;
	int flag_errs = 0;
	int run_errs = 0;

	// RD- columns, bit a or f on the left
	localparam logic [5:0] six_rdn [32] = '{
		6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
		6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
		6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
		6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
	};
	localparam logic [3:0] four_rdn [8] = '{
		4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
	};

	asi_tx_top UUT (
		.clk(clk),
		.rst(rst),
		.valid(valid),
		.data(data),
		.full(full),
		.overflow(overflow),
		.asi_out(asi_out)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////
	// reference encoder
	//////////////////////////////

	// {new rd, group with a in bit 0}, rd high means positive
	function automatic logic [10:0] enc8b10b(input logic [7:0] value, input logic k,
		input logic rd);
		logic [4:0] x;
		logic [2:0] y;
		logic [5:0] six;
		logic [3:0] four;
		logic [9:0] str;
		logic [9:0] grp;
		logic rd6;
		logic rd4;
		logic alt;
		logic flip;
		x = value[4:0];
		y = value[7:5];
		six = k ? 6'b001111 : six_rdn[x];
		// RD+ row is the complement for unbalanced rows and D.07
		if (rd && ($countones(six) != 3 || (!k && x == 5'd7))) begin
			six = ~six;
		end
		rd6 = ($countones(six) == 3) ? rd : ($countones(six) > 3);
		// A7 keeps runs of five from crossing the sub-block edge
		alt = k || (!rd6 && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
			(rd6 && (x == 5'd11 || x == 5'd13 || x == 5'd14));
		four = (alt && y == 3'd7) ? 4'b0111 : four_rdn[y];
		// balanced K28 rows take the other polarity
		if (k && $countones(four) == 2 && y != 3'd3) begin
			flip = !rd6;
		end else begin
			flip = rd6 && ($countones(four) != 2 || y == 3'd3);
		end
		if (flip) begin
			four = ~four;
		end
		rd4 = ($countones(four) == 2) ? rd6 : ($countones(four) > 2);
		str = {six, four};
		for (int i = 0; i < 10; i++) begin
			grp[i] = str[9 - i];
		end
		return {rd4, grp};
	endfunction

	assign comma_rdn = enc8b10b(8'hbc, 1'b1, 1'b0);

	//////////////////////////////
	// receive side checker
	//////////////////////////////

	task automatic check_symbol();
		logic [10:0] idle;
		logic [10:0] dat;
		int ones;
		ones = $countones(win);
		if (ones == 5 || (ones == 6 && !dsp_rd) || (ones == 4 && dsp_rd)) begin
			dsp_rd = (ones == 5) ? dsp_rd : !dsp_rd;
		end else begin
			$display("symbol %b at %0t breaks the disparity rule", win, $time);
			line_errs++;
		end
		idle = enc8b10b(8'hbc, 1'b1, line_rd);
		dat = (exp_q.size() > 0) ? enc8b10b(exp_q[0], 1'b0, line_rd) : idle;
		if (exp_q.size() > 0 && win == dat[9:0]) begin
			void'(exp_q.pop_front());
			line_rd = dat[10];
		end else if (win == idle[9:0]) begin
			line_rd = idle[10];
			comma_cnt++;
		end else begin
			$display("ERR %0t asi_out expected %b got %b", $time, dat[9:0], win);
			sym_errs++;
			// treat it as the missing byte and follow the line
			if (exp_q.size() > 0) begin
				void'(exp_q.pop_front());
			end
			line_rd = dsp_rd;
		end
	endtask

	always @(posedge clk) begin
		if (rst) begin
			aligned = 1'b0;
			win = '0;
			level = 0;
			cyc = 0;
		end else begin
			// slot of the cycle just sampled is cyc mod 10
			full_exp = (level == FIFO_DEPTH);
			pop_exp = ((cyc % 10) == REQ_SLOT) && (level > 0);
			if (full !== full_exp) begin
				$display("ERR %0t full expected %b got %b", $time, full_exp, full);
				flag_errs++;
			end
			// same edge the fifo samples
			take = valid && !full_exp;
			if (take) begin
				exp_q.push_back(data);
				acc_cnt++;
			end
			if (take && !pop_exp) begin
				level++;
			end else if (pop_exp && !take) begin
				level--;
			end
			cyc++;
			win = {asi_out, win[9:1]};
			if (!aligned) begin
				if (win == comma_rdn[9:0]) begin
					aligned = 1'b1;
					line_rd = comma_rdn[10];
					dsp_rd = 1'b1;
					nbits = 0;
					last_bit = asi_out;
					run_len = 1;
				end
			end else begin
				run_len = (asi_out == last_bit) ? run_len + 1 : 1;
				last_bit = asi_out;
				if (run_len == 6) begin
					$display("more than five equal bits on asi_out at %0t", $time);
					line_errs++;
				end
				nbits++;
				if (nbits == 10) begin
					nbits = 0;
					check_symbol();
				end
			end
		end
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////

	task automatic write_byte(input logic [7:0] b);
		@(posedge clk);
		valid <= 1'b1;
		data <= b;
		@(posedge clk);
		valid <= 1'b0;
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while (exp_q.size() > 0 && n < 400) begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() > 0) begin
			$display("%0d accepted bytes never reached asi_out", exp_q.size());
			run_errs++;
		end
		// trailing commas through the checker
		repeat (30) @(posedge clk);
	endtask

	initial begin
		int n;
		int gap;
		int acc_before;
		seed = 32'hf9debefd;
		rst = 1'b1;
		valid = 1'b0;
		data = 8'h00;
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		// idle line, commas only
		n = 0;
		while (!aligned && n < 30) begin
			@(posedge clk);
			n++;
		end
		if (!aligned) begin
			$display("no K28.5 alignment within 30 cycles of reset");
			run_errs++;
		end
		repeat (100) @(posedge clk);
		if (comma_cnt < 8) begin
			$display("idle line carried only %0d commas", comma_cnt);
			run_errs++;
		end

		// sparse random bytes, 15 to 40 cycles apart
		for (int i = 0; i < 40; i++) begin
			write_byte(8'($random(seed)));
			gap = 13 + ($unsigned($random(seed)) % 26);
			repeat (gap) @(posedge clk);
		end
		wait_drained();

		// every byte value, slower than the symbol rate
		for (int v = 0; v < 256; v++) begin
			write_byte(8'(v));
			repeat (11) @(posedge clk);
		end
		wait_drained();
		if (overflow !== 1'b0) begin
			$display("ERR %0t overflow expected 0 got %b", $time, overflow);
			run_errs++;
		end

		// back to back burst past full
		acc_before = acc_cnt;
		@(posedge clk);
		for (int i = 0; i < 40; i++) begin
			valid <= 1'b1;
			data <= 8'($random(seed));
			@(posedge clk);
		end
		valid <= 1'b0;
		@(posedge clk);
		if (overflow !== 1'b1) begin
			$display("ERR %0t overflow expected 1 got %b", $time, overflow);
			run_errs++;
		end
		if (acc_cnt - acc_before >= 40) begin
			$display("burst of 40 writes dropped no byte");
			run_errs++;
		end
		wait_drained();
		if (overflow !== 1'b1) begin
			$display("ERR %0t overflow expected 1 got %b", $time, overflow);
			run_errs++;
		end

		$display("errors: symbol %0d, line %0d, flag %0d, run %0d, assertion %0d",
			sym_errs, line_errs, flag_errs, run_errs, UUT.u_sva.fail_count);
		if (sym_errs + line_errs + flag_errs + run_errs + UUT.u_sva.fail_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule
